// ==== include/di_cfg.svh ====
// Decode-issue configuration
// Pipe count, sequence-number width and per-pipe operation masks

`ifndef DI_CFG_SVH
`define DI_CFG_SVH

// Number of execute pipes behind the issue stage
`define DI_NUM_PIPES 2

// Width of the fetch sequence number
`define DI_SEQ_BITS 5

// Operation masks, one bit per uop
// Bit 0 ADD, bit 1 ADDI, bit 2 MUL
`define DI_PIPE0_OPS 3'b011
`define DI_PIPE1_OPS 3'b111

`endif

// ==== logic/decode_issue_unit.sv ====
// Decode-issue unit
// In-order decode and issue of ADD, ADDI and MUL to several execute pipes

`timescale 1ns/100ps

`include "di_cfg.svh"

module decode_issue_unit
  import di_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,

  // Fetch side
  input  logic                       f_val,
  input  f_msg_t                     f_msg,
  output logic                       f_rdy,

  // Execute pipes
  output logic [`DI_NUM_PIPES-1:0]   x_val,
  output x_msg_t [`DI_NUM_PIPES-1:0] x_msg,
  input  logic [`DI_NUM_PIPES-1:0]   x_rdy,

  // Completion strobe
  input  logic                       complete_val,
  input  complete_t                  complete_msg
);

  logic        d_val;
  decoded_t    d_inst;
  logic [31:0] op1;
  logic [31:0] op2;
  logic        hazard;
  logic        issue;
  logic        d_release;

  decode_reg u_decode_reg (
    .clk       (clk),
    .rst       (rst),
    .f_val     (f_val),
    .f_msg     (f_msg),
    .f_rdy     (f_rdy),
    .d_release (d_release),
    .d_val     (d_val),
    .d_inst    (d_inst)
  );

  operand_file u_operand_file (
    .clk          (clk),
    .rst          (rst),
    .d_inst       (d_inst),
    .issue        (issue),
    .complete_val (complete_val),
    .complete_msg (complete_msg),
    .op1          (op1),
    .op2          (op2),
    .hazard       (hazard)
  );

  issue_router u_issue_router (
    .d_val     (d_val),
    .d_inst    (d_inst),
    .op1       (op1),
    .op2       (op2),
    .hazard    (hazard),
    .x_rdy     (x_rdy),
    .x_val     (x_val),
    .x_msg     (x_msg),
    .issue     (issue),
    .d_release (d_release)
  );

endmodule

// ==== logic/decode_reg.sv ====
// D register and instruction decoder
// Holds one fetched instruction and decodes ADD, ADDI and MUL from it

`timescale 1ns/100ps

module decode_reg
  import di_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  input  logic     f_val,
  input  f_msg_t   f_msg,
  output logic     f_rdy,

  input  logic     d_release,

  output logic     d_val,
  output decoded_t d_inst
);

  // --------------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------------

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [2:0] F3_ADD     = 3'b000;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_MULDIV  = 7'b0000001;

  // --------------------------------------------------------------------------
  // D register
  // --------------------------------------------------------------------------

  f_msg_t d_msg;
  logic   f_xfer;

  // Free slot, or the held instruction leaves this cycle
  assign f_rdy  = !d_val || d_release;
  assign f_xfer = f_val && f_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_val <= 1'b0;
    end else if (f_xfer) begin
      d_val <= 1'b1;
    end else if (d_release) begin
      d_val <= 1'b0;
    end
  end

  // Payload only, qualified by d_val
  always_ff @(posedge clk) begin
    if (f_xfer) begin
      d_msg <= f_msg;
    end
  end

  // --------------------------------------------------------------------------
  // Decoder
  // --------------------------------------------------------------------------

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = d_msg.inst[6:0];
  assign funct3 = d_msg.inst[14:12];
  assign funct7 = d_msg.inst[31:25];

  always_comb begin
    d_inst.pc      = d_msg.pc;
    d_inst.seq_num = d_msg.seq_num;
    d_inst.rs1     = d_msg.inst[19:15];
    d_inst.rs2     = d_msg.inst[24:20];
    d_inst.rd      = d_msg.inst[11:7];
    // I-type immediate, sign-extended
    d_inst.imm     = {{20{d_msg.inst[31]}}, d_msg.inst[31:20]};
    d_inst.rs2_en  = 1'b0;
    d_inst.uop     = OP_ILLEGAL;

    if (opcode == OPC_OP && funct3 == F3_ADD) begin
      if (funct7 == F7_BASE) begin
        d_inst.uop    = OP_ADD;
        d_inst.rs2_en = 1'b1;
      end else if (funct7 == F7_MULDIV) begin
        d_inst.uop    = OP_MUL;
        d_inst.rs2_en = 1'b1;
      end
    end else if (opcode == OPC_OP_IMM && funct3 == F3_ADD) begin
      d_inst.uop = OP_ADDI;
    end
  end

endmodule

// ==== logic/di_pkg.sv ====
// Decode-issue types
// Micro-op encoding and the messages passed between fetch, decode and the pipes

`include "di_cfg.svh"

package di_pkg;

  // Micro-ops, value doubles as the bit index into a pipe mask
  typedef enum logic [1:0] {
    OP_ADD     = 2'd0,
    OP_ADDI    = 2'd1,
    OP_MUL     = 2'd2,
    OP_ILLEGAL = 2'd3
  } uop_e;

  typedef logic [2:0] op_mask_t;

  typedef logic [`DI_SEQ_BITS-1:0] seq_num_t;

  // Fetch to decode
  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    seq_num_t    seq_num;
  } f_msg_t;

  // Instruction held in the D register, after decode
  typedef struct packed {
    logic [31:0] pc;
    seq_num_t    seq_num;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        rs2_en;
    logic [4:0]  rd;
    logic [31:0] imm;
    uop_e        uop;
  } decoded_t;

  // Decode to execute pipe
  typedef struct packed {
    logic [31:0] pc;
    seq_num_t    seq_num;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [4:0]  waddr;
    uop_e        uop;
  } x_msg_t;

  // Completion strobe from the pipes
  typedef struct packed {
    seq_num_t    seq_num;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } complete_t;

endpackage

// ==== logic/issue_router.sv ====
// Issue router
// Picks the lowest-numbered capable and ready pipe, drives its val and message

`timescale 1ns/100ps

`include "di_cfg.svh"

module issue_router
  import di_pkg::*;
(
  input  logic                             d_val,
  input  decoded_t                         d_inst,
  input  logic [31:0]                      op1,
  input  logic [31:0]                      op2,
  input  logic                             hazard,

  input  logic [`DI_NUM_PIPES-1:0]         x_rdy,
  output logic [`DI_NUM_PIPES-1:0]         x_val,
  output x_msg_t [`DI_NUM_PIPES-1:0]       x_msg,

  output logic                             issue,
  output logic                             d_release
);

  // Pipe capabilities, pipe 0 in the low slot
  localparam op_mask_t [`DI_NUM_PIPES-1:0] PIPE_OPS = {`DI_PIPE1_OPS, `DI_PIPE0_OPS};

  op_mask_t                 uop_bit;
  logic [`DI_NUM_PIPES-1:0] capable;
  logic [`DI_NUM_PIPES-1:0] sel;
  logic                     can_issue;
  x_msg_t                   msg;

  // Illegal shifts out of the mask and matches no pipe
  assign uop_bit   = op_mask_t'(3'b001 << d_inst.uop);
  assign can_issue = d_val && !hazard;

  // --------------------------------------------------------------------------
  // Pipe selection
  // --------------------------------------------------------------------------

  always_comb begin
    logic found;
    found = 1'b0;
    sel   = '0;
    for (int i = 0; i < `DI_NUM_PIPES; i++) begin
      capable[i] = |(PIPE_OPS[i] & uop_bit);
      if (!found && capable[i] && x_rdy[i]) begin
        sel[i] = 1'b1;
        found  = 1'b1;
      end
    end
  end

  assign x_val     = can_issue ? sel : '0;
  assign issue     = |x_val;
  assign d_release = issue || (d_val && d_inst.uop == OP_ILLEGAL);

  // --------------------------------------------------------------------------
  // Issue message, same for every pipe
  // --------------------------------------------------------------------------

  always_comb begin
    msg.pc      = d_inst.pc;
    msg.seq_num = d_inst.seq_num;
    msg.op1     = op1;
    msg.op2     = op2;
    msg.waddr   = d_inst.rd;
    msg.uop     = d_inst.uop;
  end

  always_comb begin
    for (int i = 0; i < `DI_NUM_PIPES; i++) begin
      x_msg[i] = msg;
    end
  end

endmodule

// ==== logic/operand_file.sv ====
// Operand file
// 32-entry register file with pending bits, hazard check and completion write

`timescale 1ns/100ps

module operand_file
  import di_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  input  decoded_t    d_inst,
  input  logic        issue,

  input  logic        complete_val,
  input  complete_t   complete_msg,

  output logic [31:0] op1,
  output logic [31:0] op2,
  output logic        hazard
);

  logic [31:0] regs [32];
  logic [31:0] pending;

  logic        wr_en;

  // x0 is never written, so it keeps its reset value of zero
  assign wr_en = complete_val && complete_msg.wen && (complete_msg.waddr != 5'd0);

  // --------------------------------------------------------------------------
  // Register file
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[complete_msg.waddr] <= complete_msg.wdata;
    end
  end

  // --------------------------------------------------------------------------
  // Pending bits
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (complete_val) begin
        pending[complete_msg.waddr] <= 1'b0;
      end
      // An issuing rd cannot be pending, so the set never races a clear
      if (issue && d_inst.rd != 5'd0) begin
        pending[d_inst.rd] <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Operand read and hazard check
  // --------------------------------------------------------------------------

  assign op1 = regs[d_inst.rs1];
  assign op2 = d_inst.rs2_en ? regs[d_inst.rs2] : d_inst.imm;

  // RAW on either source, WAW on the destination
  assign hazard = pending[d_inst.rs1]
                | (d_inst.rs2_en && pending[d_inst.rs2])
                | pending[d_inst.rd];

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --timescale 1ns/100ps -f tb.f --top-module tb_decode_issue \
  -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb \
  || { echo "Verilator build or run returned an error"; exit 1; }

// ==== tb.f ====
+incdir+include
logic/di_pkg.sv
logic/decode_reg.sv
logic/operand_file.sv
logic/issue_router.sv
logic/decode_issue_unit.sv
testbench/tb_decode_issue.sv

// ==== testbench/tb_decode_issue.sv ====
// Testbench for the decode-issue unit
// Directed tests with a fetch driver, pipe sinks, completions and a reference model

`timescale 1ns/100ps

`include "di_cfg.svh"

module tb_decode_issue
  import di_pkg::*;
();

  localparam int CLK_PERIOD      = 4;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;
  // Pipe capabilities by uop bit with pipe 0 in the low slot
  localparam logic [1:0][2:0] MODEL_MASK = {3'b111, 3'b011};

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    seq_num_t    seq;
  } fetched_t;

  logic                       clk;
  logic                       rst;
  logic                       f_val;
  f_msg_t                     f_msg;
  logic                       f_rdy;
  logic [`DI_NUM_PIPES-1:0]   x_val;
  x_msg_t [`DI_NUM_PIPES-1:0] x_msg;
  logic [`DI_NUM_PIPES-1:0]   x_rdy;
  logic                       complete_val;
  complete_t                  complete_msg;

  // Reference model state
  logic [31:0] model_regs [32];
  logic [31:0] model_pend;
  fetched_t    exp_q [$];
  logic [31:0] next_pc;
  seq_num_t    next_seq;
  logic [31:0] lfsr;

  decode_issue_unit u_dut (
    .clk          (clk),
    .rst          (rst),
    .f_val        (f_val),
    .f_msg        (f_msg),
    .f_rdy        (f_rdy),
    .x_val        (x_val),
    .x_msg        (x_msg),
    .x_rdy        (x_rdy),
    .complete_val (complete_val),
    .complete_msg (complete_msg)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand32();
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < 32; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // R-type ADD or MUL selected by mul
  function automatic logic [31:0] r_inst(input int mul, input int rd, input int rs1,
                                         input int rs2);
    return {6'b0, 1'(mul), 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] addi_inst(input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
  endfunction

  function automatic uop_e model_uop(input logic [31:0] inst);
    if (inst[14:12] != 3'b000) return OP_ILLEGAL;
    if (inst[6:0] == 7'b0010011) return OP_ADDI;
    if (inst[6:0] != 7'b0110011) return OP_ILLEGAL;
    if (inst[31:25] == 7'b0000000) return OP_ADD;
    if (inst[31:25] == 7'b0000001) return OP_MUL;
    return OP_ILLEGAL;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Put an instruction on the fetch port and queue it in the model if legal
  task automatic offer(input logic [31:0] inst);
    f_val         = 1'b1;
    f_msg.inst    = inst;
    f_msg.pc      = next_pc;
    f_msg.seq_num = next_seq;
    if (model_uop(inst) != OP_ILLEGAL) begin
      exp_q.push_back('{inst: inst, pc: next_pc, seq: next_seq});
    end
    next_pc  += 4;
    next_seq++;
  endtask

  // Starts and ends on a falling edge
  task automatic fetch(input logic [31:0] inst);
    offer(inst);
    #1;
    while (!f_rdy) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    f_val = 1'b0;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      #1;
      check("x_val", 32'(x_val), 32'd0);
      @(negedge clk);
    end
  endtask

  task automatic complete(input int waddr, input logic [31:0] wdata, input logic wen);
    logic [4:0] wa;
    wa                   = 5'(waddr);
    complete_val         = 1'b1;
    complete_msg.seq_num = '0;
    complete_msg.waddr   = wa;
    complete_msg.wdata   = wdata;
    complete_msg.wen     = wen;
    @(negedge clk);
    complete_val = 1'b0;
    if (wen && wa != 5'd0) model_regs[wa] = wdata;
    model_pend[wa] = 1'b0;
  endtask

  task automatic retire(input int rd);
    complete(rd, rand32(), 1'b1);
  endtask

  // The oldest expected instruction must be on a pipe in this cycle
  task automatic expect_issue();
    fetched_t                 e;
    uop_e                     uop;
    logic [4:0]               rs1;
    logic [4:0]               rs2;
    logic [4:0]               rd;
    logic [31:0]              exp_op2;
    logic [`DI_NUM_PIPES-1:0] exp_val;
    x_msg_t                   got;
    e       = exp_q.pop_front();
    uop     = model_uop(e.inst);
    rs1     = e.inst[19:15];
    rs2     = e.inst[24:20];
    rd      = e.inst[11:7];
    exp_op2 = (uop == OP_ADDI) ? 32'($signed(e.inst[31:20])) : model_regs[rs2];
    #1;
    check("x_val", 32'(|x_val), 32'd1);
    check("model pending at issue", 32'(model_pend[rs1]
          | (uop != OP_ADDI && model_pend[rs2]) | model_pend[rd]), 32'd0);
    exp_val = '0;
    // Lowest capable and ready pipe wins
    for (int i = `DI_NUM_PIPES - 1; i >= 0; i--) begin
      if (MODEL_MASK[i][uop] && x_rdy[i]) begin
        exp_val    = '0;
        exp_val[i] = 1'b1;
      end
    end
    check("x_val", 32'(x_val), 32'(exp_val));
    // Every pipe sees the same message
    for (int i = 0; i < `DI_NUM_PIPES; i++) begin
      got = x_msg[i];
      check($sformatf("x_msg[%0d].pc", i), got.pc, e.pc);
      check($sformatf("x_msg[%0d].seq_num", i), 32'(got.seq_num), 32'(e.seq));
      check($sformatf("x_msg[%0d].op1", i), got.op1, model_regs[rs1]);
      check($sformatf("x_msg[%0d].op2", i), got.op2, exp_op2);
      check($sformatf("x_msg[%0d].waddr", i), 32'(got.waddr), 32'(rd));
      check($sformatf("x_msg[%0d].uop", i), 32'(got.uop), 32'(uop));
    end
    if (rd != 5'd0) model_pend[rd] = 1'b1;
    @(negedge clk);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic test_operands();
    x_rdy = 2'b11;
    for (int r = 1; r <= 6; r++) complete(r, rand32(), 1'b1);
    fetch(r_inst(0, 7, 1, 2));
    expect_issue();
    fetch(addi_inst(8, 3, -5));
    expect_issue();
    fetch(r_inst(1, 9, 4, 5));
    expect_issue();
    retire(7);
    retire(8);
    retire(9);
  endtask

  task automatic test_pipe_select();
    x_rdy = 2'b11;
    fetch(r_inst(0, 10, 1, 2));
    expect_issue();
    retire(10);
    x_rdy = 2'b10;
    fetch(r_inst(0, 10, 3, 4));
    expect_issue();
    retire(10);
    // MUL has to wait for pipe 1
    x_rdy = 2'b01;
    fetch(r_inst(1, 11, 1, 3));
    idle(3);
    x_rdy = 2'b11;
    expect_issue();
    retire(11);
  endtask

  task automatic test_hazards();
    x_rdy = 2'b11;
    fetch(r_inst(0, 12, 1, 2));
    expect_issue();
    // RAW on x12
    fetch(r_inst(0, 13, 12, 3));
    idle(3);
    complete(12, rand32(), 1'b1);
    expect_issue();
    retire(13);
    complete(14, rand32(), 1'b1);
    fetch(r_inst(0, 14, 1, 2));
    expect_issue();
    // WAW on x14 released by a completion without wen
    fetch(r_inst(0, 14, 2, 3));
    idle(3);
    complete(14, rand32(), 1'b0);
    expect_issue();
    complete(14, rand32(), 1'b0);
    fetch(r_inst(0, 15, 14, 0));
    expect_issue();
    retire(15);
  endtask

  task automatic test_backpressure();
    x_rdy = 2'b00;
    fetch(r_inst(0, 16, 1, 2));
    offer(r_inst(1, 17, 3, 4));
    repeat (3) begin
      #1;
      check("f_rdy", 32'(f_rdy), 32'd0);
      check("x_val", 32'(x_val), 32'd0);
      @(negedge clk);
    end
    x_rdy = 2'b11;
    expect_issue();
    f_val = 1'b0;
    expect_issue();
    retire(16);
    retire(17);
  endtask

  task automatic test_illegal();
    x_rdy = 2'b11;
    fetch(r_inst(0, 18, 1, 2));
    expect_issue();
    // sw x2, 0(x1)
    fetch({7'd0, 5'd2, 5'd1, 3'b010, 5'd0, 7'b0100011});
    idle(2);
    fetch(r_inst(0, 19, 3, 4));
    expect_issue();
    retire(18);
    retire(19);
  endtask

  task automatic test_x0();
    x_rdy = 2'b11;
    complete(0, rand32(), 1'b1);
    fetch(r_inst(0, 20, 0, 0));
    expect_issue();
    fetch(r_inst(0, 0, 1, 2));
    expect_issue();
    fetch(r_inst(0, 0, 0, 3));
    expect_issue();
    fetch(addi_inst(21, 0, 100));
    expect_issue();
    retire(20);
    retire(21);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------------

  initial begin
    $timeformat(-9, 0, " ns", 0);
    clk          = 1'b0;
    rst          = 1'b1;
    f_val        = 1'b0;
    f_msg        = '0;
    x_rdy        = '0;
    complete_val = 1'b0;
    complete_msg = '0;
    next_pc      = 32'h0000_1000;
    next_seq     = '0;
    lfsr         = 32'hdc96_454b;
    model_pend   = '0;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    check("f_rdy", 32'(f_rdy), 32'd1);
    check("x_val", 32'(x_val), 32'd0);
    @(negedge clk);
    test_operands();
    test_pipe_select();
    test_hazards();
    test_backpressure();
    test_illegal();
    test_x0();
    if (exp_q.size() == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("ERROR: %0d instructions never reached a pipe", exp_q.size());
      $display("Simulation finished: FAIL");
      $fatal(1, "run incomplete");
    end
  end

  initial begin
    #(CLK_PERIOD * (NUM_TESTS * CYCLES_PER_TEST + 10));
    $display("ERROR at %0t: the tests did not finish in time", $time);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule
